// ==== src/soc_config.svh ====
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

////////////////////////////////////////////////////////////
// Bus geometry
////////////////////////////////////////////////////////////

`define SOC_DATA_W        32              // Core data word

// Address map seen by the core
`define SOC_DM_LIMIT      32'h0000_3000   // Data memory is below this
`define SOC_TC0_BASE      32'h0000_7f00
`define SOC_TC1_BASE      32'h0000_7f10
`define SOC_INT_ACK_ADDR  32'h0000_7f20   // Interrupt acknowledge write

////////////////////////////////////////////////////////////
// Timer register offsets inside a 16 byte window
////////////////////////////////////////////////////////////

`define TC_CTRL_OFS       4'h0
`define TC_PRESET_OFS     4'h4
`define TC_COUNT_OFS      4'h8            // Read only

`endif

// ==== src/bus_pkg.sv ====
package bus_pkg;

`include "soc_config.svh"

    // Target of a decoded core access
    typedef enum logic [1:0] {
        REG_DM,
        REG_TC0,
        REG_TC1,
        REG_NONE
    } bus_region_e;

    // Registered request as seen by memory and timers
    typedef struct packed {
        logic                       valid;
        logic                       write;
        bus_region_e                region;
        logic [`SOC_DATA_W-1:0]     addr;    // Word aligned
        logic [`SOC_DATA_W-1:0]     wdata;
        logic [`SOC_DATA_W/8-1:0]   byteen;
    } bus_req_t;

    typedef struct packed {
        logic                       valid;
        logic [`SOC_DATA_W-1:0]     rdata;
    } bus_resp_t;

    // Byte lane merge for masked register writes
    function automatic logic [`SOC_DATA_W-1:0] merge_bytes(
        input logic [`SOC_DATA_W-1:0]   old_w,
        input logic [`SOC_DATA_W-1:0]   new_w,
        input logic [`SOC_DATA_W/8-1:0] be
    );
        logic [`SOC_DATA_W-1:0] res;
        res = old_w;
        for (int i = 0; i < `SOC_DATA_W/8; i++) begin
            if (be[i]) res[8*i +: 8] = new_w[8*i +: 8];
        end
        return res;
    endfunction

endpackage

// ==== src/timer_pkg.sv ====
package timer_pkg;

    ////////////////////////////////////////////////////////////
    // Timer control register and FSM encodings
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        MODE_ONESHOT = 2'd0,   // Stop and hold irq at zero
        MODE_RELOAD  = 2'd1    // One cycle irq then restart
    } tc_mode_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD,
        ST_COUNT,
        ST_INT
    } tc_state_e;

    // Control word layout
    // bit 3 irq_mask
    // bits 2:1 mode
    // bit 0 enable
    typedef struct packed {
        logic     irq_mask;
        tc_mode_e mode;
        logic     enable;
    } tc_ctrl_t;

endpackage

// ==== src/bus_req_stage.sv ====
`timescale 1ns/1ps
`include "soc_config.svh"

module bus_req_stage import bus_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [`SOC_DATA_W-1:0]   cpu_addr,
    input  logic [`SOC_DATA_W-1:0]   cpu_wdata,
    input  logic [`SOC_DATA_W/8-1:0] cpu_byteen,
    input  logic                     cpu_re,
    output bus_req_t                 req
);

    ////////////////////////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////////////////////////

    // Timer windows only map ctrl, preset and count
    function automatic logic in_timer(
        input logic [`SOC_DATA_W-1:0] a,
        input logic [`SOC_DATA_W-1:0] base
    );
        return ((a & ~32'hf) == base) && (a[3:2] != 2'b11);
    endfunction

    function automatic bus_region_e decode(input logic [`SOC_DATA_W-1:0] a);
        if (a < `SOC_DM_LIMIT) return REG_DM;
        if (in_timer(a, `SOC_TC0_BASE)) return REG_TC0;
        if (in_timer(a, `SOC_TC1_BASE)) return REG_TC1;
        return REG_NONE;
    endfunction

    bus_req_t req_next;
    logic     is_write;

    assign is_write = |cpu_byteen;   // Any lane set means store

    always_comb begin
        req_next.valid  = is_write | cpu_re;
        req_next.write  = is_write;
        req_next.region = decode(cpu_addr);
        req_next.addr   = {cpu_addr[`SOC_DATA_W-1:2], 2'b00};
        req_next.wdata  = cpu_wdata;
        req_next.byteen = cpu_byteen;
    end

    ////////////////////////////////////////////////////////////
    // Request register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        req.region <= req_next.region;
        req.addr   <= req_next.addr;
        req.wdata  <= req_next.wdata;
        if (!rst_n) begin
            req.valid  <= 1'b0;
            req.write  <= 1'b0;
            req.byteen <= '0;
        end else begin
            req.valid  <= req_next.valid;   // Low on idle cycles
            req.write  <= req_next.write;
            req.byteen <= req_next.byteen;
        end
    end

endmodule

// ==== src/timer_counter.sv ====
`timescale 1ns/1ps
`include "soc_config.svh"

module timer_counter import bus_pkg::*; import timer_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  bus_req_t               req,
    input  logic                   sel,     // Region match from the top
    output logic [`SOC_DATA_W-1:0] rdata,
    output logic                   irq
);

    tc_ctrl_t               ctrl;
    logic [`SOC_DATA_W-1:0] preset;
    logic [`SOC_DATA_W-1:0] count;
    tc_state_e              state;

    logic     wr;
    logic     wr_ctrl;
    logic     wr_preset;
    logic     reload;
    tc_ctrl_t ctrl_wdata;

    assign wr         = sel && req.valid && req.write;
    assign wr_ctrl    = wr && (req.addr[3:0] == `TC_CTRL_OFS) && req.byteen[0];
    assign wr_preset  = wr && (req.addr[3:0] == `TC_PRESET_OFS);
    assign ctrl_wdata = tc_ctrl_t'(req.wdata[3:0]);
    assign reload     = (ctrl.mode == MODE_RELOAD);

    ////////////////////////////////////////////////////////////
    // Counter FSM and register writes
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ctrl   <= '0;
            preset <= '0;
            count  <= '0;
            state  <= ST_IDLE;
            irq    <= 1'b0;
        end else begin
            case (state)
                ST_LOAD: begin
                    count <= preset;
                    state <= ST_COUNT;
                end
                ST_COUNT: begin
                    if (count == '0) begin
                        state <= ST_INT;
                        irq   <= ctrl.irq_mask;
                        if (reload) count <= preset;   // Next period starts now
                    end else begin
                        count <= count - 1'b1;
                    end
                end
                ST_INT: begin
                    if (!reload) begin
                        ctrl.enable <= 1'b0;   // One shot is done
                        state       <= ST_IDLE;
                    end else if (count == '0) begin
                        irq <= ctrl.irq_mask;  // Zero preset fires every cycle
                    end else begin
                        irq   <= 1'b0;
                        count <= count - 1'b1;
                        state <= ST_COUNT;
                    end
                end
                default: state <= ST_IDLE;
            endcase

            // Bus writes win over the FSM
            if (wr_preset) begin
                preset <= merge_bytes(preset, req.wdata, req.byteen);
                irq    <= 1'b0;
            end
            if (wr_ctrl) begin
                ctrl  <= ctrl_wdata;
                irq   <= 1'b0;
                state <= ctrl_wdata.enable ? ST_LOAD : ST_IDLE;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Register read
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (req.addr[3:0])
            `TC_CTRL_OFS:   rdata = {{(`SOC_DATA_W-4){1'b0}}, ctrl};
            `TC_PRESET_OFS: rdata = preset;
            `TC_COUNT_OFS:  rdata = count;
            default:        rdata = '0;
        endcase
    end

endmodule

// ==== src/bus_resp_stage.sv ====
`timescale 1ns/1ps
`include "soc_config.svh"

module bus_resp_stage import bus_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,
    input  bus_req_t                 req,
    input  logic [`SOC_DATA_W-1:0]   mem_rdata,
    input  logic [`SOC_DATA_W-1:0]   tc0_rdata,
    input  logic [`SOC_DATA_W-1:0]   tc1_rdata,
    input  logic                     int_ack,
    input  logic                     ext_int,
    output logic [`SOC_DATA_W-1:0]   mem_addr,
    output logic [`SOC_DATA_W-1:0]   mem_wdata,
    output logic [`SOC_DATA_W/8-1:0] mem_byteen,
    output bus_resp_t                resp,
    output logic [`SOC_DATA_W-1:0]   int_addr,
    output logic [`SOC_DATA_W/8-1:0] int_byteen
);

    logic                   is_dm;
    logic                   ack_hit;
    logic [`SOC_DATA_W-1:0] rd_next;

    ////////////////////////////////////////////////////////////
    // Data memory port
    ////////////////////////////////////////////////////////////

    assign is_dm      = req.valid && (req.region == REG_DM);
    assign mem_addr   = is_dm ? req.addr : '0;
    assign mem_wdata  = is_dm ? req.wdata : '0;
    assign mem_byteen = (is_dm && req.write) ? req.byteen : '0;

    // Acknowledge store while the core takes the external interrupt
    assign ack_hit    = int_ack && ext_int;
    assign int_addr   = ack_hit ? `SOC_INT_ACK_ADDR : '0;
    assign int_byteen = ack_hit ? 4'b0001 : 4'b0000;

    ////////////////////////////////////////////////////////////
    // Read return
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (req.region)
            REG_DM:  rd_next = mem_rdata;
            REG_TC0: rd_next = tc0_rdata;
            REG_TC1: rd_next = tc1_rdata;
            default: rd_next = '0;          // Unmapped reads
        endcase
    end

    always_ff @(posedge clk) begin
        resp.rdata <= rd_next;
        if (!rst_n) resp.valid <= 1'b0;
        else        resp.valid <= req.valid && !req.write;
    end

endmodule

// ==== src/soc_bus_top.sv ====
`timescale 1ns/1ps
`include "soc_config.svh"

module soc_bus_top import bus_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [`SOC_DATA_W-1:0]   cpu_addr,
    input  logic [`SOC_DATA_W-1:0]   cpu_wdata,
    input  logic [`SOC_DATA_W/8-1:0] cpu_byteen,
    input  logic                     cpu_re,
    input  logic                     int_ack,   // Core is servicing an interrupt
    input  logic                     ext_int,
    input  logic [`SOC_DATA_W-1:0]   mem_rdata,
    output logic [`SOC_DATA_W-1:0]   mem_addr,
    output logic [`SOC_DATA_W-1:0]   mem_wdata,
    output logic [`SOC_DATA_W/8-1:0] mem_byteen,
    output logic [`SOC_DATA_W-1:0]   cpu_rdata,
    output logic                     rdata_valid,
    output logic [`SOC_DATA_W-1:0]   int_addr,
    output logic [`SOC_DATA_W/8-1:0] int_byteen,
    output logic [5:0]               hw_int
);

    bus_req_t               req;
    bus_resp_t              resp;
    logic [`SOC_DATA_W-1:0] tc0_rdata;
    logic [`SOC_DATA_W-1:0] tc1_rdata;
    logic                   irq0;
    logic                   irq1;

    bus_req_stage i_req (
        .clk, .rst_n, .cpu_addr, .cpu_wdata, .cpu_byteen, .cpu_re, .req
    );

    ////////////////////////////////////////////////////////////
    // Timers
    ////////////////////////////////////////////////////////////

    timer_counter i_tc0 (
        .clk, .rst_n, .req,
        .sel   (req.region == REG_TC0),
        .rdata (tc0_rdata),
        .irq   (irq0)
    );

    timer_counter i_tc1 (
        .clk, .rst_n, .req,
        .sel   (req.region == REG_TC1),
        .rdata (tc1_rdata),
        .irq   (irq1)
    );

    bus_resp_stage i_resp (
        .clk, .rst_n, .req, .mem_rdata, .tc0_rdata, .tc1_rdata, .int_ack, .ext_int,
        .mem_addr, .mem_wdata, .mem_byteen, .resp, .int_addr, .int_byteen
    );

    assign cpu_rdata   = resp.rdata;
    assign rdata_valid = resp.valid;
    assign hw_int      = {3'b000, ext_int, irq1, irq0};   // Upper lines unused

endmodule

// ==== tests/soc_bus_properties.sv ====
`timescale 1ns/1ps
`include "soc_config.svh"

module soc_bus_properties (
    input logic                     clk,
    input logic                     rst_n,
    input logic [`SOC_DATA_W-1:0]   cpu_addr,
    input logic [`SOC_DATA_W/8-1:0] cpu_byteen,
    input logic                     cpu_re,
    input logic [`SOC_DATA_W/8-1:0] mem_byteen,
    input logic                     rdata_valid,
    input logic [5:0]               hw_int
);

    reset_values: assert property (@(posedge clk)
        !rst_n |=> (!rdata_valid && mem_byteen == '0 && hw_int[1:0] == 2'b00))
        else $error("rdata_valid, mem_byteen or timer irq not cleared by reset");

    // Memory stores only come from a DM write of the previous cycle
    dm_only_store: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_byteen != '0) |-> (mem_byteen == $past(cpu_byteen)
                                && $past(cpu_addr) < `SOC_DM_LIMIT))
        else $error("memory store without a DM write one cycle earlier");

    // Read data returns two cycles after a read strobe
    read_return: assert property (@(posedge clk) disable iff (!rst_n)
        rdata_valid |-> ($past(cpu_re, 2) && $past(cpu_byteen, 2) == '0))
        else $error("rdata_valid without a read request two cycles earlier");

endmodule

bind soc_bus_top soc_bus_properties i_props (.*);

// ==== tests/tb_soc_bus.sv ====
`timescale 1ns/1ps
`include "soc_config.svh"

module tb_soc_bus;

    typedef enum {K_WR, K_RD, K_WAIT, K_IRQ, K_SIG} kind_e;

    localparam int MAX_PRESET = 5;   // Longest timer run in the table

    logic        clk;
    logic        rst_n;
    logic [31:0] cpu_addr;
    logic [31:0] cpu_wdata;
    logic [3:0]  cpu_byteen;
    logic        cpu_re;
    logic        int_ack;
    logic        ext_int;
    logic [31:0] mem_rdata;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [3:0]  mem_byteen;
    logic [31:0] cpu_rdata;
    logic        rdata_valid;
    logic [31:0] int_addr;
    logic [3:0]  int_byteen;
    logic [5:0]  hw_int;

    logic [31:0] dm_model [0:3071];   // One word per DM address
    integer      seed;
    int          cycle;
    int          ref_cycle;           // Edge of last timer event
    int          errors;
    int          limit;

    // Test table columns
    string       t_name [$];
    kind_e       t_kind [$];
    logic [31:0] t_addr [$];          // Bit index for K_IRQ
    logic [31:0] t_data [$];          // Cycles for K_WAIT and K_IRQ, {ack, ext} for K_SIG
    logic [3:0]  t_be [$];
    logic [31:0] t_exp [$];

    soc_bus_top i_soc_bus_top (.*);

    assign mem_rdata = dm_model[mem_addr[13:2]];

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle > limit) begin
            $display("Timeout: run stopped after %0d cycles", cycle);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic add_test(input string n, input kind_e k, input logic [31:0] a,
                            input logic [31:0] d, input logic [3:0] be, input logic [31:0] e);
        t_name.push_back(n);
        t_kind.push_back(k);
        t_addr.push_back(a);
        t_data.push_back(d);
        t_be.push_back(be);
        t_exp.push_back(e);
    endtask

    task automatic report_mismatch(input string n, input logic [31:0] e, input logic [31:0] a);
        errors++;
        $display("** Error %s: expected %h, actual %h", n, e, a);
    endtask

    ////////////////////////////////////////////////////////////
    // One table row
    ////////////////////////////////////////////////////////////

    task automatic run_test(input int i);
        logic [31:0] exp_rd;
        logic [31:0] exp_ack;
        int          bit_n;
        bit_n   = t_addr[i][1:0];
        exp_ack = (t_exp[i] != 0) ? `SOC_INT_ACK_ADDR : 32'h0;
        exp_rd  = (t_addr[i] < `SOC_DM_LIMIT) ? dm_model[t_addr[i][13:2]] : t_exp[i];
        case (t_kind[i])
            K_WR, K_RD: begin
                @(posedge clk);
                cpu_addr   <= t_addr[i];
                cpu_wdata  <= t_data[i];
                cpu_byteen <= (t_kind[i] == K_WR) ? t_be[i] : 4'h0;
                cpu_re     <= (t_kind[i] == K_RD);
                @(posedge clk);
                cpu_byteen <= 4'h0;
                cpu_re     <= 1'b0;
                @(negedge clk);   // Memory port is live now
                if (t_kind[i] == K_WR && t_addr[i] < `SOC_DM_LIMIT) begin
                    if (mem_addr !== (t_addr[i] & ~32'h3))
                        report_mismatch({t_name[i], " mem_addr"}, t_addr[i] & ~32'h3, mem_addr);
                    if (mem_wdata !== t_data[i])
                        report_mismatch({t_name[i], " mem_wdata"}, t_data[i], mem_wdata);
                    if (mem_byteen !== t_be[i])
                        report_mismatch({t_name[i], " mem_byteen"}, t_be[i], mem_byteen);
                end else if (mem_byteen !== 4'h0) begin
                    report_mismatch({t_name[i], " mem_byteen"}, 0, mem_byteen);
                end
                @(posedge clk);
                @(negedge clk);
                if (t_kind[i] == K_WR)
                    ref_cycle = cycle;   // Timer applies the write here
                if (t_kind[i] == K_RD && rdata_valid !== 1'b1) begin
                    errors++;
                    $display("%s: no read data returned two cycles after the request", t_name[i]);
                end else if (t_kind[i] == K_RD && cpu_rdata !== exp_rd) begin
                    report_mismatch({t_name[i], " cpu_rdata"}, exp_rd, cpu_rdata);
                end else if (t_kind[i] == K_WR && rdata_valid !== 1'b0) begin
                    errors++;
                    $display("%s: read data valid raised by a write", t_name[i]);
                end
            end
            K_WAIT: begin
                repeat (t_data[i]) @(negedge clk);
                if (hw_int !== t_exp[i][5:0])
                    report_mismatch({t_name[i], " hw_int"}, t_exp[i], hw_int);
            end
            K_IRQ: begin
                @(negedge clk);
                while (hw_int[bit_n] !== 1'b1) @(negedge clk);
                if (cycle - ref_cycle !== t_data[i])
                    report_mismatch({t_name[i], " rise cycle"}, t_data[i], cycle - ref_cycle);
                ref_cycle = cycle;
                @(negedge clk);   // One cycle after the rise
                if (hw_int[bit_n] !== t_exp[i][0])
                    report_mismatch({t_name[i], " irq level"}, t_exp[i][0], hw_int[bit_n]);
            end
            default: begin
                @(posedge clk);
                int_ack <= t_data[i][1];
                ext_int <= t_data[i][0];
                @(negedge clk);
                if (hw_int[2] !== t_data[i][0])
                    report_mismatch({t_name[i], " hw_int[2]"}, t_data[i][0], hw_int[2]);
                if (int_byteen !== t_exp[i][3:0])
                    report_mismatch({t_name[i], " int_byteen"}, t_exp[i], int_byteen);
                if (int_addr !== exp_ack)
                    report_mismatch({t_name[i], " int_addr"}, exp_ack, int_addr);
            end
        endcase
    endtask

    initial begin
        int w;
        int i;
        int prev;
        clk        = 1'b0;
        rst_n      = 1'b0;
        cpu_addr   = '0;
        cpu_wdata  = '0;
        cpu_byteen = '0;
        cpu_re     = 1'b0;
        int_ack    = 1'b0;
        ext_int    = 1'b0;
        cycle      = 0;
        ref_cycle  = 0;
        errors     = 0;
        seed       = 83;
        for (w = 0; w < 3072; w++)
            dm_model[w] = $random(seed) ^ (w << 2);

        add_test("dm_wr_full",    K_WR,   32'h0104, 32'ha5a5_1234, 4'hf, 0);
        add_test("dm_wr_mask",    K_WR,   32'h0206, 32'h00c3_0000, 4'b0100, 0);
        add_test("dm_rd_lo",      K_RD,   32'h0040, 0, 4'h0, 0);
        add_test("dm_rd_hi",      K_RD,   32'h2ffc, 0, 4'h0, 0);
        add_test("tc0_pre_wr",    K_WR,   32'h7f04, 32'h1234_5678, 4'hf, 0);
        add_test("tc0_pre_byte",  K_WR,   32'h7f04, 32'h00ab_0000, 4'b0100, 0);
        add_test("tc0_pre_rd",    K_RD,   32'h7f04, 0, 4'h0, 32'h12ab_5678);
        add_test("tc0_ctrl_wr",   K_WR,   32'h7f00, 32'h8, 4'hf, 0);
        add_test("tc0_ctrl_byte", K_WR,   32'h7f00, 32'hff07, 4'b0010, 0);
        add_test("tc0_ctrl_rd",   K_RD,   32'h7f00, 0, 4'h0, 32'h8);
        add_test("tc0_cnt_wr",    K_WR,   32'h7f08, 32'hdead, 4'hf, 0);
        add_test("tc0_cnt_rd",    K_RD,   32'h7f08, 0, 4'h0, 0);
        add_test("unmapped_rd",   K_RD,   32'h7f0c, 0, 4'h0, 0);
        add_test("tc0_pre5",      K_WR,   32'h7f04, 32'd5, 4'hf, 0);
        add_test("tc0_start",     K_WR,   32'h7f00, 32'h9, 4'hf, 0);
        add_test("tc0_irq",       K_IRQ,  0, 32'd7, 4'h0, 1);
        add_test("tc0_hold",      K_WAIT, 0, 32'd3, 4'h0, 32'h01);
        add_test("tc0_done_rd",   K_RD,   32'h7f00, 0, 4'h0, 32'h8);
        add_test("tc0_clear",     K_WR,   32'h7f00, 32'h8, 4'hf, 0);
        add_test("tc0_cleared",   K_WAIT, 0, 32'd1, 4'h0, 32'h00);
        add_test("tc1_pre3",      K_WR,   32'h7f14, 32'd3, 4'hf, 0);
        add_test("tc1_start",     K_WR,   32'h7f10, 32'hb, 4'hf, 0);
        add_test("tc1_irq_a",     K_IRQ,  1, 32'd5, 4'h0, 0);
        add_test("tc1_irq_b",     K_IRQ,  1, 32'd4, 4'h0, 0);
        add_test("tc1_irq_c",     K_IRQ,  1, 32'd4, 4'h0, 0);
        add_test("tc1_stop",      K_WR,   32'h7f10, 32'h0, 4'hf, 0);
        add_test("tc1_quiet",     K_WAIT, 0, 32'd6, 4'h0, 32'h00);
        add_test("ext_only",      K_SIG,  0, 32'b01, 4'h0, 0);
        add_test("ext_ack",       K_SIG,  0, 32'b11, 4'h0, 32'h1);
        add_test("ack_only",      K_SIG,  0, 32'b10, 4'h0, 0);
        add_test("ext_low",       K_SIG,  0, 32'b00, 4'h0, 0);
        limit = t_name.size() * (MAX_PRESET + 8);

        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        if (rdata_valid !== 1'b0)
            report_mismatch("reset rdata_valid", 0, rdata_valid);
        if (mem_byteen !== 4'h0)
            report_mismatch("reset mem_byteen", 0, mem_byteen);
        if (int_byteen !== 4'h0)
            report_mismatch("reset int_byteen", 0, int_byteen);
        if (hw_int !== 6'h0)
            report_mismatch("reset hw_int", 0, hw_int);
        $display("test %-14s %s", "reset", (errors == 0) ? "ok" : "failed");

        for (i = 0; i < t_name.size(); i++) begin
            prev = errors;
            run_test(i);
            $display("test %-14s %s", t_name[i], (errors == prev) ? "ok" : "failed");
        end

        $display("Tests: %0d  Errors: %0d", t_name.size() + 1, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+src
src/bus_pkg.sv
src/timer_pkg.sv
src/bus_req_stage.sv
src/timer_counter.sv
src/bus_resp_stage.sv
src/soc_bus_top.sv
tests/soc_bus_properties.sv
tests/tb_soc_bus.sv
